// File: include/sine_quarter.svh
// Quarter-wave sine magnitudes that the channel and its reference model include for the lookup.

// Entry i holds round(32767 * sin((i + 0.5) * pi / 32)).
localparam logic [14:0] SINE_QUARTER [16] = '{
    15'd1608,  15'd4808,  15'd7962,  15'd11039,
    15'd14010, 15'd16846, 15'd19519, 15'd22005,
    15'd24279, 15'd26319, 15'd28105, 15'd29621,
    15'd30851, 15'd31785, 15'd32412, 15'd32728
};

// File: verilog/opl_pkg.sv
// Widths, register map, state encodings and parameter types shared by the FM channel design.
package opl_pkg;

    localparam int PHASE_W    = 20;                      // Operator phase accumulator.
    localparam int SAMPLE_W   = 16;                      // Signed audio sample.
    localparam int GAIN_W     = 8;                       // Linear gain, 255 is near unity.
    localparam int FIFO_DEPTH = 2;                       // Transmitter entries and reset credits.
    localparam int SCLK_HALF  = 4;                       // clk125 cycles per sclk half period.
    localparam int CREDIT_W   = $clog2(FIFO_DEPTH + 1);  // Holds 0..FIFO_DEPTH.
    localparam int PTR_W      = $clog2(FIFO_DEPTH);      // Buffer index.
    localparam int DIV_W      = $clog2(2 * SCLK_HALF);   // Serial clock divider.
    localparam int SLOT_W     = 5;                       // 32 bit slots per frame.
    localparam int IDX_W      = 6;                       // Sine index taken from the phase top.

    // Byte-wide register map.
    typedef enum logic [3:0] {
        ADDR_FNUM_LO = 4'h0,  // fnum[7:0].
        ADDR_FNUM_HI = 4'h1,  // fnum[9:8], block, key-on.
        ADDR_MULT0   = 4'h2,
        ADDR_MULT1   = 4'h3,
        ADDR_RATE0   = 4'h4,  // Attack high nibble, release low nibble.
        ADDR_RATE1   = 4'h5,
        ADDR_LEVEL0  = 4'h6,
        ADDR_LEVEL1  = 4'h7,
        ADDR_MODE    = 4'h8   // cnt, cha, chb.
    } reg_addr_e;

    typedef struct packed {
        logic [3:0]        mult;   // Frequency multiplier.
        logic [3:0]        ar;     // Attack step, times 4.
        logic [3:0]        rr;     // Release step, times 4.
        logic [GAIN_W-1:0] level;  // Sustain gain.
    } op_params_t;

    typedef struct packed {
        logic [9:0]      fnum;
        logic [2:0]      block;
        logic            kon;
        logic            cnt;  // 0 is FM, 1 is additive.
        logic            cha;  // Left enable.
        logic            chb;  // Right enable.
        op_params_t [1:0] op;
    } ch_params_t;

    typedef enum logic [1:0] {ENV_IDLE, ENV_ATTACK, ENV_SUSTAIN, ENV_RELEASE} env_state_e;

    typedef enum logic [1:0] {CH_IDLE, CH_OP0, CH_OP1, CH_MIX} chan_state_e;

endpackage

// File: verilog/sample_if.sv
// Stereo sample link with credit return, used between the FM channel and the I2S transmitter.
`timescale 1ns/1ps

interface sample_if import opl_pkg::*; ();

    logic                       valid;   // One-cycle sample strobe.
    logic signed [SAMPLE_W-1:0] left;    // Qualified by valid.
    logic signed [SAMPLE_W-1:0] right;   // Qualified by valid.
    logic                       credit;  // One buffer entry freed.

    modport src (
        output valid, left, right,
        input  credit
    );

    modport snk (
        input  valid, left, right,
        output credit
    );

endinterface

// File: verilog/opl_regs.sv
// Register file that turns byte writes into the channel parameter bundle for the FM channel.
`timescale 1ns/1ps

module opl_regs import opl_pkg::*; (
    input  logic       clk125,
    input  logic       rst,
    input  logic       wr_en,
    input  logic [3:0] wr_addr,
    input  logic [7:0] wr_data,
    output ch_params_t params
);

    always_ff @(posedge clk125) begin
        if (rst) begin
            params <= '0;  // All fields cleared, key off.
        end else if (wr_en) begin
            case (reg_addr_e'(wr_addr))
                ADDR_FNUM_LO: params.fnum[7:0] <= wr_data;
                ADDR_FNUM_HI: begin
                    params.fnum[9:8] <= wr_data[1:0];
                    params.block     <= wr_data[4:2];
                    params.kon       <= wr_data[5];   // Edge seen at next sample start.
                end
                ADDR_MULT0:   params.op[0].mult <= wr_data[3:0];
                ADDR_MULT1:   params.op[1].mult <= wr_data[3:0];
                ADDR_RATE0: begin
                    params.op[0].ar <= wr_data[7:4];
                    params.op[0].rr <= wr_data[3:0];
                end
                ADDR_RATE1: begin
                    params.op[1].ar <= wr_data[7:4];
                    params.op[1].rr <= wr_data[3:0];
                end
                ADDR_LEVEL0:  params.op[0].level <= wr_data;
                ADDR_LEVEL1:  params.op[1].level <= wr_data;
                ADDR_MODE: begin
                    params.cnt <= wr_data[0];
                    params.cha <= wr_data[4];
                    params.chb <= wr_data[5];
                end
                default: ;  // Unmapped, ignored.
            endcase
        end
    end

    // An unknown address would silently corrupt or skip a field.
    a_addr_known: assert property (@(posedge clk125) disable iff (rst)
        wr_en |-> !$isunknown(wr_addr))
        else $error("register write with unknown address");

endmodule

// File: verilog/phase_gen.sv
// Phase accumulator of one FM operator, stepped once per sample and cleared on key-on.
`timescale 1ns/1ps

module phase_gen import opl_pkg::*; (
    input  logic               clk125,
    input  logic               rst,
    input  logic               step,   // Advance after use.
    input  logic               clear,  // Key-on restart.
    input  logic [9:0]         fnum,
    input  logic [2:0]         block,
    input  logic [3:0]         mult,
    output logic [PHASE_W-1:0] phase
);

    logic [PHASE_W-1:0] inc;

    // fnum << block times mult, wrapped to the accumulator width.
    assign inc = (PHASE_W'(fnum) << block) * PHASE_W'(mult);

    always_ff @(posedge clk125) begin
        if (rst) begin
            phase <= '0;
        end else if (clear) begin
            phase <= '0;  // Restart at zero phase.
        end else if (step) begin
            phase <= phase + inc;  // Modulo 2^PHASE_W.
        end
    end

    // The sequencer keeps restart and advance in separate cycles.
    a_no_clear_step: assert property (@(posedge clk125) disable iff (rst)
        !(clear && step))
        else $error("phase clear and step in the same cycle");

endmodule

// File: verilog/envelope_gen.sv
// Linear attack, sustain and release gain generator of one FM operator.
`timescale 1ns/1ps

module envelope_gen import opl_pkg::*; (
    input  logic              clk125,
    input  logic              rst,
    input  logic              step,     // Once per sample, after use.
    input  logic              key_on,
    input  logic              key_off,
    input  logic [3:0]        ar,
    input  logic [3:0]        rr,
    input  logic [GAIN_W-1:0] level,
    output logic [GAIN_W-1:0] gain
);

    env_state_e        state;
    logic [GAIN_W:0]   attack_sum;  // One spare bit for overshoot.
    logic [GAIN_W-1:0] rel_step;

    assign attack_sum = gain + {ar, 2'b00};
    assign rel_step   = {2'b00, rr, 2'b00};

    always_ff @(posedge clk125) begin
        if (rst) begin
            state <= ENV_IDLE;
            gain  <= '0;
        end else if (key_on) begin
            state <= ENV_ATTACK;  // Ramp up from the present gain.
        end else if (key_off) begin
            state <= ENV_RELEASE;
        end else if (step) begin
            case (state)
                ENV_ATTACK: begin
                    if (attack_sum >= {1'b0, level}) begin
                        gain  <= level;  // Saturate.
                        state <= ENV_SUSTAIN;
                    end else begin
                        gain <= attack_sum[GAIN_W-1:0];
                    end
                end
                ENV_SUSTAIN: gain <= level;  // Tracks level writes.
                ENV_RELEASE: begin
                    if (gain <= rel_step) begin
                        gain  <= '0;
                        state <= ENV_IDLE;
                    end else begin
                        gain <= gain - rel_step;
                    end
                end
                default: gain <= '0;
            endcase
        end
    end

    // After each update the gain sits at or under level unless releasing.
    a_gain_bound: assert property (@(posedge clk125) disable iff (rst)
        step |=> (state == ENV_RELEASE || gain <= level))
        else $error("envelope gain above level outside release");

endmodule

// File: verilog/fm_channel.sv
// Two-operator FM channel sequencer that produces one panned stereo sample per transmitter credit.
`timescale 1ns/1ps

module fm_channel import opl_pkg::*; (
    input  logic       clk125,
    input  logic       rst,
    input  ch_params_t params,
    sample_if.src      src
);

`include "sine_quarter.svh"

    chan_state_e                state;
    ch_params_t                 p;           // Parameters of the sample in flight.
    logic                       kon_prev;    // Key-on of the previous sample.
    logic [CREDIT_W-1:0]        credits;
    logic                       start;
    logic                       kon_rise;
    logic                       kon_fall;
    logic                       op_sel;      // 0 for operator 0, 1 for operator 1.
    logic [1:0]                 op_step;
    logic [PHASE_W-1:0]         phase [2];
    logic [GAIN_W-1:0]          gain [2];
    logic [PHASE_W-1:0]         mod;
    logic [PHASE_W-1:0]         op_phase;
    logic [IDX_W-1:0]           idx;
    logic [3:0]                 entry;
    logic signed [SAMPLE_W-1:0] sine;
    logic signed [SAMPLE_W+GAIN_W:0] product;
    logic signed [SAMPLE_W-1:0] op_out;
    logic signed [SAMPLE_W-1:0] op0_out;     // Held from CH_OP1.
    logic signed [SAMPLE_W:0]   mix_sum;
    logic signed [SAMPLE_W-1:0] mix;

    assign start    = (state == CH_IDLE) && (credits != '0);
    assign kon_rise = (state == CH_OP0) && p.kon && !kon_prev;
    assign kon_fall = (state == CH_OP0) && !p.kon && kon_prev;
    assign op_sel   = (state == CH_MIX);
    assign op_step  = {state == CH_MIX, state == CH_OP1};  // Step after each use.

    for (genvar i = 0; i < 2; i++) begin : g_op
        phase_gen u_phase (
            .clk125 (clk125),
            .rst    (rst),
            .step   (op_step[i]),
            .clear  (kon_rise),
            .fnum   (p.fnum),
            .block  (p.block),
            .mult   (p.op[i].mult),
            .phase  (phase[i])
        );

        envelope_gen u_env (
            .clk125  (clk125),
            .rst     (rst),
            .step    (op_step[i]),
            .key_on  (kon_rise),
            .key_off (kon_fall),
            .ar      (p.op[i].ar),
            .rr      (p.op[i].rr),
            .level   (p.op[i].level),
            .gain    (gain[i])
        );
    end

    // One shared lookup path with the operator picked by state.
    assign mod      = p.cnt ? '0 : {op0_out, 4'b0000};  // FM modulation by op0 << 4.
    assign op_phase = op_sel ? phase[1] + mod : phase[0];
    assign idx      = op_phase[PHASE_W-1 -: IDX_W];
    assign entry    = idx[4] ? ~idx[3:0] : idx[3:0];   // Mirror second quarter.
    assign sine     = idx[5] ? -$signed({1'b0, SINE_QUARTER[entry]})
                             : $signed({1'b0, SINE_QUARTER[entry]});
    assign product  = sine * $signed({1'b0, gain[op_sel]});
    assign op_out   = product[SAMPLE_W+GAIN_W-1:GAIN_W];  // Arithmetic >> 8.
    assign mix_sum  = op0_out + op_out;
    assign mix      = p.cnt ? mix_sum[SAMPLE_W:1] : op_out;  // Additive halves the sum.

    always_ff @(posedge clk125) begin
        if (rst) begin
            state     <= CH_IDLE;
            p         <= '0;
            kon_prev  <= 1'b0;
            credits   <= CREDIT_W'(FIFO_DEPTH);  // Buffer starts empty.
            src.valid <= 1'b0;
        end else begin
            src.valid <= 1'b0;
            case ({start, src.credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ;  // No change when both or neither.
            endcase
            case (state)
                CH_IDLE: begin
                    if (start) begin
                        p        <= params;  // Latch once per sample.
                        kon_prev <= p.kon;
                        state    <= CH_OP0;
                    end
                end
                CH_OP0:  state <= CH_OP1;  // Key events applied here.
                CH_OP1:  state <= CH_MIX;
                default: begin
                    src.valid <= 1'b1;
                    state     <= CH_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk125) begin
        if (state == CH_OP1) begin
            op0_out <= op_out;
        end
        if (state == CH_MIX) begin
            src.left  <= p.cha ? mix : '0;  // Pan left.
            src.right <= p.chb ? mix : '0;  // Pan right.
        end
    end

    a_credit_bound: assert property (@(posedge clk125) disable iff (rst)
        credits <= CREDIT_W'(FIFO_DEPTH))
        else $error("credit counter out of range");

endmodule

// File: verilog/i2s_tx.sv
// Two-entry sample buffer and I2S serialiser that hands back one credit per frame it sends.
`timescale 1ns/1ps

module i2s_tx import opl_pkg::*; (
    input  logic   clk125,
    input  logic   rst,
    sample_if.snk  snk,
    output logic   i2s_sclk,
    output logic   i2s_ws,
    output logic   i2s_sd
);

    logic [2*SAMPLE_W-1:0] fifo_mem [FIFO_DEPTH];  // {left, right}.
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CREDIT_W-1:0]   count;
    logic [DIV_W-1:0]      div;
    logic [SLOT_W-1:0]     slot;
    logic [SLOT_W-1:0]     slot_next;
    logic [2*SAMPLE_W-1:0] shreg;
    logic                  tick_rise;
    logic                  tick_fall;
    logic                  frame_start;
    logic                  pop;

    assign tick_rise   = (div == DIV_W'(SCLK_HALF - 1));
    assign tick_fall   = (div == DIV_W'(2 * SCLK_HALF - 1));  // Slot boundary.
    assign slot_next   = slot + 1'b1;
    assign frame_start = tick_fall && (slot == '1);
    assign pop         = frame_start && (count != '0);
    assign snk.credit  = pop;  // Same cycle as the pop.

    always_ff @(posedge clk125) begin
        if (snk.valid) begin
            fifo_mem[wr_ptr] <= {snk.left, snk.right};
        end
    end

    always_ff @(posedge clk125) begin
        if (rst) begin
            div      <= '0;
            slot     <= '0;
            shreg    <= '0;  // First frame goes out silent.
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            i2s_sclk <= 1'b0;
            i2s_ws   <= 1'b0;
            i2s_sd   <= 1'b0;
        end else begin
            div <= tick_fall ? '0 : div + 1'b1;
            if (tick_rise) begin
                i2s_sclk <= 1'b1;
            end
            if (tick_fall) begin
                i2s_sclk <= 1'b0;
                slot     <= slot_next;
                i2s_ws   <= slot_next[SLOT_W-1];  // High for slots 16..31.
                i2s_sd   <= shreg[2*SAMPLE_W-1];  // MSB lands one slot after ws.
                if (frame_start) begin
                    shreg <= pop ? fifo_mem[rd_ptr] : '0;  // Underrun sends zeros.
                end else begin
                    shreg <= shreg << 1;
                end
            end
            if (snk.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({snk.valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // Credits returned to the channel must keep it from overfilling the buffer.
    a_no_overflow: assert property (@(posedge clk125) disable iff (rst)
        snk.valid |-> count < CREDIT_W'(FIFO_DEPTH))
        else $error("sample arrived while transmitter buffer full");

endmodule

// File: verilog/opl_core.sv
// Top level of the FM subsystem, tying register port, channel and I2S transmitter together.
`timescale 1ns/1ps

module opl_core import opl_pkg::*; (
    input  logic       clk125,
    input  logic       rst,
    input  logic       wr_en,
    input  logic [3:0] wr_addr,
    input  logic [7:0] wr_data,
    output logic       i2s_sclk,
    output logic       i2s_ws,
    output logic       i2s_sd
);

    ch_params_t params;  // Register file to channel.

    sample_if smp ();    // Channel to transmitter.

    opl_regs u_regs (
        .clk125  (clk125),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .params  (params)
    );

    fm_channel u_channel (
        .clk125 (clk125),
        .rst    (rst),
        .params (params),
        .src    (smp.src)
    );

    i2s_tx u_i2s (
        .clk125   (clk125),
        .rst      (rst),
        .snk      (smp.snk),
        .i2s_sclk (i2s_sclk),
        .i2s_ws   (i2s_ws),
        .i2s_sd   (i2s_sd)
    );

endmodule

// File: sim/opl_checker.sv
// Testbench monitor that decodes the I2S pins, runs the FM reference model and compares frames.
`timescale 1ns/1ps

module opl_checker import opl_pkg::*; (
    input  logic       clk125,
    input  logic       rst,
    input  logic       wr_en,
    input  logic [3:0] wr_addr,
    input  logic [7:0] wr_data,
    input  logic       i2s_sclk,
    input  logic       i2s_ws,
    input  logic       i2s_sd,
    output int         frame_count,  // Decoded frames so far.
    output int         err_left,
    output int         err_right,
    output int         err_other
);

`include "sine_quarter.svh"

    ch_params_t        shadow;        // Register values as written.
    logic              m_kon_prev;
    logic [19:0]       m_phase [2];
    int                m_gain [2];
    env_state_e        m_env [2];
    logic signed [15:0] exp_l [$];    // Model samples still in flight.
    logic signed [15:0] exp_r [$];
    logic              last_ws;       // ws at the previous clock.
    logic              last_sclk;
    logic              bit_ws;        // ws at the previous sclk rise.
    logic [31:0]       frame_sr;
    int                gap;           // Cycles since the last sclk rise.
    logic              seen_rise;
    int                ws_bits;       // sclk rises since the last ws change.
    logic              ws_seen;

    // Quarter-table lookup with mirror and sign, then gain and >>> 8.
    function automatic int op_value(input logic [19:0] ph, input int g);
        logic [5:0] idx;
        logic [3:0] e;
        int         v;
        idx = ph[19:14];
        e = idx[4] ? ~idx[3:0] : idx[3:0];
        v = int'(SINE_QUARTER[e]);
        if (idx[5]) v = -v;
        return (v * g) >>> 8;
    endfunction

    // One sample of the reference model from the latched register values.
    task automatic run_model(input ch_params_t p, output logic signed [15:0] l,
                             output logic signed [15:0] r);
        int          s0;
        int          s1;
        int          mix;
        int          inc;
        int          sum;
        logic [19:0] ph;
        if (p.kon && !m_kon_prev) begin
            for (int i = 0; i < 2; i++) begin
                m_phase[i] = '0;        // Restart both operators.
                m_env[i]   = ENV_ATTACK;
            end
        end else if (!p.kon && m_kon_prev) begin
            m_env[0] = ENV_RELEASE;
            m_env[1] = ENV_RELEASE;
        end
        m_kon_prev = p.kon;
        s0 = op_value(m_phase[0], m_gain[0]);
        ph = m_phase[1] + (p.cnt ? 20'd0 : 20'(s0 << 4));  // FM modulation.
        s1 = op_value(ph, m_gain[1]);
        mix = p.cnt ? (s0 + s1) >>> 1 : s1;
        l = p.cha ? 16'(mix) : 16'sd0;
        r = p.chb ? 16'(mix) : 16'sd0;
        for (int i = 0; i < 2; i++) begin
            inc = (int'(p.fnum) << p.block) * int'(p.op[i].mult);
            m_phase[i] = m_phase[i] + 20'(inc);  // Advance after use.
            case (m_env[i])
                ENV_ATTACK: begin
                    sum = m_gain[i] + 4 * int'(p.op[i].ar);
                    if (sum >= int'(p.op[i].level)) begin
                        m_gain[i] = int'(p.op[i].level);
                        m_env[i]  = ENV_SUSTAIN;
                    end else begin
                        m_gain[i] = sum;
                    end
                end
                ENV_SUSTAIN: m_gain[i] = int'(p.op[i].level);
                ENV_RELEASE: begin
                    if (m_gain[i] <= 4 * int'(p.op[i].rr)) begin
                        m_gain[i] = 0;
                        m_env[i]  = ENV_IDLE;
                    end else begin
                        m_gain[i] = m_gain[i] - 4 * int'(p.op[i].rr);
                    end
                end
                default: m_gain[i] = 0;
            endcase
        end
    endtask

    always @(posedge clk125) begin
        logic signed [15:0] l;
        logic signed [15:0] r;
        logic signed [15:0] el;
        logic signed [15:0] er;
        logic [31:0]        f;
        if (rst) begin
            shadow = '0;
            m_kon_prev = 1'b0;
            for (int i = 0; i < 2; i++) begin
                m_phase[i] = '0;
                m_gain[i]  = 0;
                m_env[i]   = ENV_IDLE;
            end
            exp_l.delete();
            exp_r.delete();
            last_ws = 1'b0;
            last_sclk = 1'b0;
            bit_ws = 1'b0;
            frame_sr = '0;
            gap = 0;
            seen_rise = 1'b0;
            ws_bits = 0;
            ws_seen = 1'b0;
            frame_count = 0;
            err_left = 0;
            err_right = 0;
            err_other = 0;
        end else begin
            // Frame start was one edge ago so the channel latches a new sample now.
            if (last_ws && !i2s_ws) begin
                run_model(shadow, l, r);
                if (exp_l.size() == 4) begin
                    void'(exp_l.pop_front());
                    void'(exp_r.pop_front());
                end
                exp_l.push_back(l);
                exp_r.push_back(r);
            end
            last_ws = i2s_ws;
            if (wr_en) begin
                case (reg_addr_e'(wr_addr))
                    ADDR_FNUM_LO: shadow.fnum[7:0] = wr_data;
                    ADDR_FNUM_HI: begin
                        shadow.fnum[9:8] = wr_data[1:0];
                        shadow.block = wr_data[4:2];
                        shadow.kon = wr_data[5];
                    end
                    ADDR_MULT0:  shadow.op[0].mult = wr_data[3:0];
                    ADDR_MULT1:  shadow.op[1].mult = wr_data[3:0];
                    ADDR_RATE0:  {shadow.op[0].ar, shadow.op[0].rr} = wr_data;
                    ADDR_RATE1:  {shadow.op[1].ar, shadow.op[1].rr} = wr_data;
                    ADDR_LEVEL0: shadow.op[0].level = wr_data;
                    ADDR_LEVEL1: shadow.op[1].level = wr_data;
                    ADDR_MODE: begin
                        shadow.cnt = wr_data[0];
                        shadow.cha = wr_data[4];
                        shadow.chb = wr_data[5];
                    end
                    default: ;
                endcase
            end
            gap = gap + 1;
            if (i2s_sclk && !last_sclk) begin
                if (seen_rise && gap != 2 * SCLK_HALF) begin
                    err_other++;
                    $display("At %0t the serial clock period was %0d cycles instead of 8",
                             $time, gap);
                end
                seen_rise = 1'b1;
                gap = 0;
                f = {frame_sr[30:0], i2s_sd};
                frame_sr = f;
                // Right LSB arrives in the first slot with ws low again.
                if (bit_ws && !i2s_ws) begin
                    el = (exp_l.size() == 4) ? exp_l[0] : 16'sd0;
                    er = (exp_r.size() == 4) ? exp_r[0] : 16'sd0;
                    if ($signed(f[31:16]) != el) begin
                        err_left++;
                        $display("[ERROR] %0t left expected %0d actual %0d",
                                 $time, el, $signed(f[31:16]));
                    end
                    if ($signed(f[15:0]) != er) begin
                        err_right++;
                        $display("[ERROR] %0t right expected %0d actual %0d",
                                 $time, er, $signed(f[15:0]));
                    end
                    frame_count++;
                end
                // Each ws half carries one 16-bit word.
                ws_bits++;
                if (i2s_ws != bit_ws) begin
                    if (ws_seen && ws_bits != 16) begin
                        err_other++;
                        $display("At %0t word select changed after %0d bit slots instead of 16",
                                 $time, ws_bits);
                    end
                    ws_seen = 1'b1;
                    ws_bits = 0;
                end
                bit_ws = i2s_ws;
            end
            last_sclk = i2s_sclk;
        end
    end

endmodule

// File: sim/opl_tb.sv
// Testbench top for the FM subsystem, driving random register settings and reporting the result.
`timescale 1ns/1ps

module opl_tb;

    logic       clk125;
    logic       rst;
    logic       wr_en;
    logic [3:0] wr_addr;
    logic [7:0] wr_data;
    logic       i2s_sclk;
    logic       i2s_ws;
    logic       i2s_sd;
    int         frame_count;
    int         err_left;
    int         err_right;
    int         err_other;
    int         timeouts;     // Expired frame waits.
    logic [31:0] lfsr;        // Galois LFSR state.
    logic [7:0]  fnum_hi;     // Last FNUM_HI byte without key-on.
    logic [31:0] v;

    opl_core u_opl_core (
        .clk125   (clk125),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .i2s_sclk (i2s_sclk),
        .i2s_ws   (i2s_ws),
        .i2s_sd   (i2s_sd)
    );

    opl_checker u_checker (
        .clk125      (clk125),
        .rst         (rst),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .i2s_sclk    (i2s_sclk),
        .i2s_ws      (i2s_ws),
        .i2s_sd      (i2s_sd),
        .frame_count (frame_count),
        .err_left    (err_left),
        .err_right   (err_right),
        .err_other   (err_other)
    );

    initial begin
        clk125 = 1'b0;
        forever #5 clk125 = ~clk125;  // 10 ns period.
    end

    // Steps the LFSR once per bit taken.
    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [7:0] data);
        @(posedge clk125);
        wr_en   <= 1'b1;
        wr_addr <= addr;
        wr_data <= data;
        @(posedge clk125);
        wr_en   <= 1'b0;
    endtask

    // Waits for decoded frames up to a cycle budget.
    task automatic wait_frames(input int n);
        int target;
        int cycles;
        target = frame_count + n;
        cycles = 0;
        while (timeouts == 0 && frame_count < target && cycles < n * 256 + 2000) begin
            @(posedge clk125);
            cycles++;
        end
        if (timeouts == 0 && frame_count < target) begin
            $display("Timed out waiting for I2S frames from the DUT");
            timeouts++;
        end
    endtask

    // Random voice with nonzero rates so ramps always move.
    task automatic configure(input logic cnt, input logic cha, input logic chb);
        logic [31:0] a;
        logic [31:0] r;
        rand_bits(8, a);
        write_reg(4'h0, a[7:0]);
        rand_bits(5, a);
        fnum_hi = {3'b000, a[4:0]};
        write_reg(4'h1, fnum_hi);
        for (int i = 0; i < 2; i++) begin
            rand_bits(4, a);
            write_reg(4'(2 + i), {4'h0, a[3:0]});
            rand_bits(4, a);
            rand_bits(4, r);
            write_reg(4'(4 + i), {(a[3:0] == 0) ? 4'h1 : a[3:0],
                                  (r[3:0] == 0) ? 4'h1 : r[3:0]});
            rand_bits(8, a);
            write_reg(4'(6 + i), a[7:0]);
        end
        write_reg(4'h8, {2'b00, chb, cha, 3'b000, cnt});
    endtask

    initial begin
        lfsr     = 32'hbd85_d7b0;
        timeouts = 0;
        rst      = 1'b1;
        wr_en    = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        fnum_hi  = '0;
        repeat (2) @(posedge clk125);
        rst <= 1'b0;
        wait_frames(8);                       // Idle output is silent.
        configure(1'b0, 1'b1, 1'b1);          // FM mode.
        write_reg(4'h1, fnum_hi | 8'h20);
        wait_frames(52);
        write_reg(4'h1, fnum_hi);             // Release to silence.
        wait_frames(80);
        configure(1'b1, 1'b1, 1'b1);          // Additive mode.
        write_reg(4'h1, fnum_hi | 8'h20);
        wait_frames(52);
        write_reg(4'h1, fnum_hi);
        wait_frames(80);
        for (int pan = 0; pan < 4; pan++) begin
            rand_bits(1, v);
            configure(v[0], pan[0], pan[1]);
            write_reg(4'h1, fnum_hi | 8'h20);
            wait_frames(20);
            write_reg(4'h1, fnum_hi);
            wait_frames(70);
        end
        configure(1'b0, 1'b1, 1'b1);
        write_reg(4'h1, fnum_hi | 8'h20);
        repeat (32) begin                     // Long run with writes mixed in.
            rand_bits(4, v);
            write_random_byte(v[3:0]);
            rand_bits(3, v);
            wait_frames(8 + v[2:0]);
        end
        wait_frames(4);
        $display("Errors: left %0d, right %0d, other %0d, timeouts %0d",
                 err_left, err_right, err_other, timeouts);
        if (timeouts == 0 && err_left + err_right + err_other == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Random byte to any address including unmapped ones.
    task automatic write_random_byte(input logic [3:0] addr);
        logic [31:0] d;
        rand_bits(8, d);
        write_reg(addr, d[7:0]);
    endtask

endmodule

// File: project.f
+incdir+include
verilog/opl_pkg.sv
verilog/sample_if.sv
verilog/opl_regs.sv
verilog/phase_gen.sv
verilog/envelope_gen.sv
verilog/fm_channel.sv
verilog/i2s_tx.sv
verilog/opl_core.sv
sim/opl_checker.sv
sim/opl_tb.sv

// File: Bender.yml
package:
  name: opl_fm

sources:
  - include_dirs:
      - include
    files:
      - verilog/opl_pkg.sv
      - verilog/sample_if.sv
      - verilog/opl_regs.sv
      - verilog/phase_gen.sv
      - verilog/envelope_gen.sv
      - verilog/fm_channel.sv
      - verilog/i2s_tx.sv
      - verilog/opl_core.sv
      - target: test
        files:
          - sim/opl_checker.sv
          - sim/opl_tb.sv
